/* filelist.f */
hdl/cpu_pkg.sv
hdl/controller.sv
hdl/regfile.sv
hdl/alu.sv
hdl/pc.sv
hdl/muxs.sv
hdl/regwalls.sv
hdl/cpu_top.sv
test/tb_cpu_top.sv

/* hdl/alu.sv */
module alu (
	input  cpu_pkg::alu_op_t alu_op,
	input  cpu_pkg::word_t   src1,
	input  cpu_pkg::word_t   src2,
	output cpu_pkg::word_t   result,
	output logic             zero,
	output logic             overflow
);
	always_comb begin
		result   = '0;
		overflow = 1'b0;
		case (alu_op)
			cpu_pkg::ALU_ADD: begin
				result = src1 + src2;
				// same-sign operands giving a result of the other sign
				overflow = (src1[31] == src2[31]) && (result[31] != src1[31]);
			end
			cpu_pkg::ALU_SUB: begin
				result = src1 - src2;
				overflow = (src1[31] != src2[31]) && (result[31] != src1[31]);
			end
			cpu_pkg::ALU_AND: begin
				result = src1 & src2;
			end
			cpu_pkg::ALU_OR: begin
				result = src1 | src2;
			end
			cpu_pkg::ALU_XOR: begin
				result = src1 ^ src2;
			end
			cpu_pkg::ALU_SLT: begin
				result = {31'b0, $signed(src1) < $signed(src2)};
			end
			cpu_pkg::ALU_PASS2: begin
				result = src2;
			end
			default: begin
				result = '0;
			end
		endcase
	end

	// used by branches after a subtract
	assign zero = (result == '0);

endmodule

/* hdl/controller.sv */
module controller (
	input  cpu_pkg::word_t     instruction,
	output cpu_pkg::ctrl_t     ctrl,
	output cpu_pkg::reg_addr_t ra_addr,
	output cpu_pkg::reg_addr_t rb_addr,
	output cpu_pkg::reg_addr_t rt_addr,
	output cpu_pkg::word_t     imm_raw
);
	logic [5:0] opcode;
	logic [4:0] sub_op;
	cpu_pkg::reg_addr_t rt_field;
	cpu_pkg::reg_addr_t rb_field;

	assign opcode   = instruction[cpu_pkg::OPC_LSB +: 6];
	assign sub_op   = instruction[4:0];
	assign rt_field = instruction[cpu_pkg::RT_LSB +: 5];
	assign rb_field = instruction[cpu_pkg::RB_LSB +: 5];

	assign ra_addr = instruction[cpu_pkg::RA_LSB +: 5];
	assign rt_addr = rt_field;

	// the immediate kind picks how much of this field counts
	assign imm_raw = {12'b0, instruction[19:0]};

	always_comb begin
		ctrl          = '0;
		ctrl.alu_op   = cpu_pkg::ALU_ADD;
		ctrl.imm_kind = cpu_pkg::IMM_NONE;
		rb_addr       = rb_field;
		case (opcode)
			cpu_pkg::OP_ALU: begin
				ctrl.reg_write = 1'b1;
				case (sub_op)
					cpu_pkg::SUB_ADD: ctrl.alu_op = cpu_pkg::ALU_ADD;
					cpu_pkg::SUB_SUB: ctrl.alu_op = cpu_pkg::ALU_SUB;
					cpu_pkg::SUB_AND: ctrl.alu_op = cpu_pkg::ALU_AND;
					cpu_pkg::SUB_OR:  ctrl.alu_op = cpu_pkg::ALU_OR;
					cpu_pkg::SUB_XOR: ctrl.alu_op = cpu_pkg::ALU_XOR;
					cpu_pkg::SUB_SLT: ctrl.alu_op = cpu_pkg::ALU_SLT;
					// unknown sub-op behaves as a nop
					default: ctrl.reg_write = 1'b0;
				endcase
			end
			cpu_pkg::OP_ADDI: begin
				ctrl.src2_imm  = 1'b1;
				ctrl.imm_kind  = cpu_pkg::IMM_K15;
				ctrl.reg_write = 1'b1;
			end
			cpu_pkg::OP_MOVI: begin
				ctrl.alu_op    = cpu_pkg::ALU_PASS2;
				ctrl.src2_imm  = 1'b1;
				ctrl.imm_kind  = cpu_pkg::IMM_K20;
				ctrl.reg_write = 1'b1;
			end
			cpu_pkg::OP_LWI: begin
				ctrl.src2_imm  = 1'b1;
				ctrl.imm_kind  = cpu_pkg::IMM_K15;
				ctrl.reg_write = 1'b1;
				ctrl.dm_read   = 1'b1;
			end
			cpu_pkg::OP_SWI: begin
				// store data is read through the rt port
				ctrl.src2_imm = 1'b1;
				ctrl.imm_kind = cpu_pkg::IMM_K15;
				ctrl.dm_write = 1'b1;
			end
			cpu_pkg::OP_BEQ, cpu_pkg::OP_BNE: begin
				// rt goes to the rb port for the compare with ra
				ctrl.alu_op   = cpu_pkg::ALU_SUB;
				ctrl.imm_kind = cpu_pkg::IMM_K14;
				ctrl.is_beq   = (opcode == cpu_pkg::OP_BEQ);
				ctrl.is_bne   = (opcode == cpu_pkg::OP_BNE);
				rb_addr       = rt_field;
			end
			default: begin
				ctrl.reg_write = 1'b0;
			end
		endcase
	end

endmodule

/* hdl/cpu_pkg.sv */
package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [9:0]  pc_t;
	typedef logic [11:0] dm_addr_t;
	typedef logic [2:0]  alu_op_t;
	typedef logic [1:0]  imm_kind_t;

	localparam int NUM_REGS = 32;

	// instruction field positions, bit 31 stays zero
	localparam int OPC_LSB = 25;
	localparam int RT_LSB  = 20;
	localparam int RA_LSB  = 15;
	localparam int RB_LSB  = 10;

	localparam logic [5:0] OP_ALU  = 6'b100000;
	localparam logic [5:0] OP_ADDI = 6'b101000;
	localparam logic [5:0] OP_MOVI = 6'b100010;
	localparam logic [5:0] OP_LWI  = 6'b000010;
	localparam logic [5:0] OP_SWI  = 6'b001010;
	localparam logic [5:0] OP_BEQ  = 6'b100110;
	localparam logic [5:0] OP_BNE  = 6'b100111;

	// sub-operation in bits 4..0 of an OP_ALU instruction
	localparam logic [4:0] SUB_ADD = 5'b00000;
	localparam logic [4:0] SUB_SUB = 5'b00001;
	localparam logic [4:0] SUB_AND = 5'b00010;
	localparam logic [4:0] SUB_XOR = 5'b00011;
	localparam logic [4:0] SUB_OR  = 5'b00100;
	localparam logic [4:0] SUB_SLT = 5'b00110;

	localparam alu_op_t ALU_ADD   = 3'd0;
	localparam alu_op_t ALU_SUB   = 3'd1;
	localparam alu_op_t ALU_AND   = 3'd2;
	localparam alu_op_t ALU_OR    = 3'd3;
	localparam alu_op_t ALU_XOR   = 3'd4;
	localparam alu_op_t ALU_SLT   = 3'd5;
	localparam alu_op_t ALU_PASS2 = 3'd6;

	localparam imm_kind_t IMM_NONE = 2'd0;
	localparam imm_kind_t IMM_K14  = 2'd1;
	localparam imm_kind_t IMM_K15  = 2'd2;
	localparam imm_kind_t IMM_K20  = 2'd3;

	typedef struct packed {
		alu_op_t   alu_op;
		logic      src2_imm;
		imm_kind_t imm_kind;
		logic      reg_write;
		logic      dm_read;
		logic      dm_write;
		logic      is_beq;
		logic      is_bne;
	} ctrl_t;

	typedef struct packed {
		logic  valid;
		pc_t   pc;
		word_t instruction;
	} if_id_t;

	typedef struct packed {
		logic      valid;
		pc_t       pc;
		ctrl_t     ctrl;
		word_t     ra_data;
		word_t     rt_data;
		word_t     imm;
		word_t     src2;
		reg_addr_t wr_addr;
	} id_ex_t;

	typedef struct packed {
		logic      valid;
		logic      reg_write;
		logic      dm_read;
		logic      dm_write;
		word_t     alu_result;
		word_t     rt_data;
		logic      overflow;
		reg_addr_t wr_addr;
	} ex_mem_t;

	typedef struct packed {
		logic      valid;
		logic      reg_write;
		word_t     write_data;
		reg_addr_t wr_addr;
	} mem_wb_t;

endpackage

/* hdl/cpu_top.sv */
module cpu_top (
	input  logic               clk,
	input  logic               reset,
	input  cpu_pkg::word_t     instruction,
	input  cpu_pkg::word_t     dm_out,
	output logic               im_read,
	output logic               im_enable,
	output cpu_pkg::pc_t       im_address,
	output logic               dm_read,
	output logic               dm_write,
	output logic               dm_enable,
	output cpu_pkg::dm_addr_t  dm_address,
	output cpu_pkg::word_t     dm_in,
	output logic               alu_overflow
);
	cpu_pkg::if_id_t  if_id, if_id_next;
	cpu_pkg::id_ex_t  id_ex, id_ex_next;
	cpu_pkg::ex_mem_t ex_mem, ex_mem_next;
	cpu_pkg::mem_wb_t mem_wb, mem_wb_next;

	// decode
	cpu_pkg::ctrl_t     ctrl;
	cpu_pkg::reg_addr_t ra_addr;
	cpu_pkg::reg_addr_t rb_addr;
	cpu_pkg::reg_addr_t rt_addr;
	cpu_pkg::word_t     imm_raw;
	cpu_pkg::word_t     imm_ext;
	cpu_pkg::word_t     alu_src2;
	cpu_pkg::word_t     ra_data;
	cpu_pkg::word_t     rb_data;
	cpu_pkg::word_t     rt_data;

	// execute and later
	cpu_pkg::word_t alu_result;
	logic           alu_zero;
	logic           alu_ovf;
	logic           branch_taken;
	cpu_pkg::pc_t   current_pc;
	cpu_pkg::word_t write_data;

	assign im_read    = !reset;
	assign im_enable  = !reset;
	assign dm_enable  = !reset;
	assign im_address = current_pc;

	assign dm_read      = ex_mem.dm_read;
	assign dm_write     = ex_mem.dm_write;
	assign dm_address   = ex_mem.alu_result[11:0];
	assign dm_in        = ex_mem.rt_data;
	assign alu_overflow = ex_mem.overflow;

	assign if_id_next = '{valid: 1'b1, pc: current_pc, instruction: instruction};

	assign id_ex_next = '{
		valid: if_id.valid, pc: if_id.pc, ctrl: ctrl,
		ra_data: ra_data, rt_data: rt_data, imm: imm_ext,
		src2: alu_src2, wr_addr: rt_addr
	};

	// memory strobes and overflow are qualified here so the outputs come straight from flops
	assign ex_mem_next = '{
		valid: id_ex.valid, reg_write: id_ex.ctrl.reg_write,
		dm_read: id_ex.valid && id_ex.ctrl.dm_read,
		dm_write: id_ex.valid && id_ex.ctrl.dm_write,
		alu_result: alu_result, rt_data: id_ex.rt_data,
		overflow: id_ex.valid && id_ex.ctrl.reg_write && !id_ex.ctrl.dm_read && alu_ovf,
		wr_addr: id_ex.wr_addr
	};

	assign mem_wb_next = '{
		valid: ex_mem.valid, reg_write: ex_mem.reg_write,
		write_data: write_data, wr_addr: ex_mem.wr_addr
	};

	controller u_controller (
		.instruction (if_id.instruction),
		.ctrl        (ctrl),
		.ra_addr     (ra_addr),
		.rb_addr     (rb_addr),
		.rt_addr     (rt_addr),
		.imm_raw     (imm_raw)
	);

	regfile u_regfile (
		.clk          (clk),
		.reset        (reset),
		.ra_addr      (ra_addr),
		.rb_addr      (rb_addr),
		.rt_addr      (rt_addr),
		.write_addr   (mem_wb.wr_addr),
		.write_data   (mem_wb.write_data),
		.write_enable (mem_wb.valid && mem_wb.reg_write),
		.ra_data      (ra_data),
		.rb_data      (rb_data),
		.rt_data      (rt_data)
	);

	muxs u_muxs (
		.ctrl        (ctrl),
		.imm_raw     (imm_raw),
		.rb_data     (rb_data),
		.alu_result  (ex_mem.alu_result),
		.dm_out      (dm_out),
		.mem_is_load (ex_mem.dm_read),
		.imm_ext     (imm_ext),
		.alu_src2    (alu_src2),
		.write_data  (write_data)
	);

	alu u_alu (
		.alu_op   (id_ex.ctrl.alu_op),
		.src1     (id_ex.ra_data),
		.src2     (id_ex.src2),
		.result   (alu_result),
		.zero     (alu_zero),
		.overflow (alu_ovf)
	);

	pc u_pc (
		.clk          (clk),
		.reset        (reset),
		.id_ex        (id_ex),
		.alu_zero     (alu_zero),
		.current_pc   (current_pc),
		.branch_taken (branch_taken)
	);

	regwalls u_regwalls (
		.clk          (clk),
		.reset        (reset),
		.branch_taken (branch_taken),
		.if_id_next   (if_id_next),
		.id_ex_next   (id_ex_next),
		.ex_mem_next  (ex_mem_next),
		.mem_wb_next  (mem_wb_next),
		.if_id        (if_id),
		.id_ex        (id_ex),
		.ex_mem       (ex_mem),
		.mem_wb       (mem_wb)
	);

endmodule

/* hdl/muxs.sv */
module muxs (
	input  cpu_pkg::ctrl_t ctrl,
	input  cpu_pkg::word_t imm_raw,
	input  cpu_pkg::word_t rb_data,
	input  cpu_pkg::word_t alu_result,
	input  cpu_pkg::word_t dm_out,
	input  logic           mem_is_load,
	output cpu_pkg::word_t imm_ext,
	output cpu_pkg::word_t alu_src2,
	output cpu_pkg::word_t write_data
);
	// sign extension by immediate kind
	always_comb begin
		case (ctrl.imm_kind)
			cpu_pkg::IMM_K14: imm_ext = {{18{imm_raw[13]}}, imm_raw[13:0]};
			cpu_pkg::IMM_K15: imm_ext = {{17{imm_raw[14]}}, imm_raw[14:0]};
			cpu_pkg::IMM_K20: imm_ext = {{12{imm_raw[19]}}, imm_raw[19:0]};
			default:          imm_ext = '0;
		endcase
	end

	// decode stage operand select
	assign alu_src2 = ctrl.src2_imm ? imm_ext : rb_data;

	// memory stage result select
	assign write_data = mem_is_load ? dm_out : alu_result;

endmodule

/* hdl/pc.sv */
module pc (
	input  logic            clk,
	input  logic            reset,
	input  cpu_pkg::id_ex_t id_ex,
	input  logic            alu_zero,
	output cpu_pkg::pc_t    current_pc,
	output logic            branch_taken
);
	cpu_pkg::pc_t branch_target;

	// word offset relative to the branch itself
	assign branch_target = id_ex.pc + id_ex.imm[9:0];

	assign branch_taken = id_ex.valid &&
		((id_ex.ctrl.is_beq && alu_zero) || (id_ex.ctrl.is_bne && !alu_zero));

	always_ff @(posedge clk) begin
		if (reset)
			current_pc <= '0;
		else if (branch_taken)
			current_pc <= branch_target;
		else
			current_pc <= current_pc + 1'b1;
	end

	// the slot behind a taken branch reaches EX already squashed
	flush_after_branch: assert property (
		@(posedge clk) disable iff (reset)
		branch_taken |=> !id_ex.valid
	);

endmodule

/* hdl/regfile.sv */
module regfile (
	input  logic               clk,
	input  logic               reset,
	input  cpu_pkg::reg_addr_t ra_addr,
	input  cpu_pkg::reg_addr_t rb_addr,
	input  cpu_pkg::reg_addr_t rt_addr,
	input  cpu_pkg::reg_addr_t write_addr,
	input  cpu_pkg::word_t     write_data,
	input  logic               write_enable,
	output cpu_pkg::word_t     ra_data,
	output cpu_pkg::word_t     rb_data,
	output cpu_pkg::word_t     rt_data
);
	cpu_pkg::word_t regs [cpu_pkg::NUM_REGS];

	// write before read, a pending write wins over the stored value
	function automatic cpu_pkg::word_t read_port(cpu_pkg::reg_addr_t addr);
		if (write_enable && write_addr == addr)
			return write_data;
		return regs[addr];
	endfunction

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < cpu_pkg::NUM_REGS; i++)
				regs[i] <= '0;
		end else if (write_enable) begin
			regs[write_addr] <= write_data;
		end
	end

	always_comb begin
		ra_data = read_port(ra_addr);
		rb_data = read_port(rb_addr);
		rt_data = read_port(rt_addr);
	end

endmodule

/* hdl/regwalls.sv */
module regwalls (
	input  logic             clk,
	input  logic             reset,
	input  logic             branch_taken,
	input  cpu_pkg::if_id_t  if_id_next,
	input  cpu_pkg::id_ex_t  id_ex_next,
	input  cpu_pkg::ex_mem_t ex_mem_next,
	input  cpu_pkg::mem_wb_t mem_wb_next,
	output cpu_pkg::if_id_t  if_id,
	output cpu_pkg::id_ex_t  id_ex,
	output cpu_pkg::ex_mem_t ex_mem,
	output cpu_pkg::mem_wb_t mem_wb
);
	always_ff @(posedge clk) begin
		if (reset) begin
			if_id  <= '0;
			id_ex  <= '0;
			ex_mem <= '0;
			mem_wb <= '0;
		end else begin
			if_id  <= if_id_next;
			id_ex  <= id_ex_next;
			ex_mem <= ex_mem_next;
			mem_wb <= mem_wb_next;
			// the two slots behind a taken branch are squashed
			if (branch_taken) begin
				if_id.valid <= 1'b0;
				id_ex.valid <= 1'b0;
			end
		end
	end

endmodule

/* test/cpu_tests.txt */
// per test: program length, program words, preload count, preload address/data pairs,
// store count, expected store address/data pairs, overflow pulse count, cycle budget
// all values hex, the first word is the number of tests
4

// test 0: register alu operations on movi operands
14
44100007 442FFFFD 50000000 50000000
40308800 40408801 40508802 40608804 40708803
40808806 40910406 50000000 50000000
14300010 14400011 14500012 14600013 14700014 14800015 14900016
0
7
010 00000004  011 0000000A  012 00000005  013 FFFFFFFF
014 FFFFFFFA  015 00000000  016 00000001
0 40

// test 1: negative immediates, loads, stores at computed offsets
10
441FFFFF 4427FFFF 44300022 5040FF9C 50510001
0461FFFE 04700021 50000000 50000000 40831C00
14400030 14500031 14100032 50000000 14838005 1461FFFF
2
020 12345678  021 00000100
5
030 FFFFFF9B  031 00080000  032 FFFFFFFF  105 12345778  021 12345678
0 40

// test 2: taken and not-taken beq and bne, a counted loop
1B
44100005 44200005 44300009 50000000 50000000
4C208004 14100040 14100041 14100042 14300043
4E208004 14200044 4E308003 14300045 14300046
4C308003 14100047 44400003 50000000 50000000
50427FFF 50000000 50000000 14420050 4E403FFC
14100060 14200061
0
8
043 00000009  044 00000005  047 00000005  052 00000002
051 00000001  050 00000000  060 00000005  061 00000005
0 80

// test 3: signed overflow, the flushed add must not count or write
19
04100000 04200001 44300001 50000000 50000000
40408C00 40508800 40610C01 40708C01 50808001
50000000 50917FFF 50A10005 4C000003 40C08C00
40C08C00 50000000 14400070 14500071 14600072
14700073 14800074 14900075 14A00076 14C00077
2
000 7FFFFFFF  001 80000000
8
070 80000000  071 FFFFFFFF  072 7FFFFFFF  073 7FFFFFFE
074 80000000  075 7FFFFFFF  076 80000005  077 00000000
4 40

/* test/tb_cpu_top.sv */
module tb_cpu_top;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int PROG_WORDS = 1024;
	localparam int DM_WORDS = 4096;
	localparam int FILE_WORDS = 1024;
	localparam int RESET_CYCLES = 16;
	localparam int DRAIN_CYCLES = 8;
	// addi r0 = r0 + 0
	localparam cpu_pkg::word_t NOP = {1'b0, cpu_pkg::OP_ADDI, 25'b0};

	logic clk;
	logic reset;
	cpu_pkg::word_t instruction;
	cpu_pkg::word_t dm_out;
	logic im_read;
	logic im_enable;
	cpu_pkg::pc_t im_address;
	logic dm_read;
	logic dm_write;
	logic dm_enable;
	cpu_pkg::dm_addr_t dm_address;
	cpu_pkg::word_t dm_in;
	logic alu_overflow;

	cpu_pkg::word_t prog [PROG_WORDS];
	cpu_pkg::word_t dmem [DM_WORDS];
	logic [31:0] test_words [FILE_WORDS];
	int cursor;
	cpu_pkg::dm_addr_t exp_addr [$];
	cpu_pkg::word_t exp_data [$];

	cpu_top u_cpu_top (
		.clk          (clk),
		.reset        (reset),
		.instruction  (instruction),
		.dm_out       (dm_out),
		.im_read      (im_read),
		.im_enable    (im_enable),
		.im_address   (im_address),
		.dm_read      (dm_read),
		.dm_write     (dm_write),
		.dm_enable    (dm_enable),
		.dm_address   (dm_address),
		.dm_in        (dm_in),
		.alu_overflow (alu_overflow)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// instruction memory returns nop for unlisted words
	always @(posedge clk) begin
		#1;
		instruction = prog[im_address];
	end

	always @(posedge clk) begin
		if (dm_write)
			dmem[dm_address] <= dm_in;
	end

	// read data only while a load strobes dm_read
	assign dm_out = dm_read ? dmem[dm_address] : 'x;

	function automatic cpu_pkg::word_t fill_value(cpu_pkg::dm_addr_t addr);
		return {8'hA5, ~addr, addr};
	endfunction

	task automatic abort_run();
		$display("Testbench failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic mismatch(input string msg);
		$display("CHECK FAILED at time %0t: %s", $time, msg);
		abort_run();
	endtask

	task automatic give_up(input string msg);
		$display("%s", msg);
		abort_run();
	endtask

	task automatic read_word(output cpu_pkg::word_t w);
		w = test_words[cursor];
		if (cursor >= FILE_WORDS || $isunknown(w))
			give_up($sformatf("test data file is short or broken at word %0d", cursor));
		cursor++;
	endtask

	task automatic fill_memories();
		for (int a = 0; a < PROG_WORDS; a++)
			prog[a] = NOP;
		for (int a = 0; a < DM_WORDS; a++)
			dmem[a] = fill_value(cpu_pkg::dm_addr_t'(a));
	endtask

	task automatic load_test(output cpu_pkg::word_t exp_ovf, output cpu_pkg::word_t budget);
		cpu_pkg::word_t count;
		cpu_pkg::word_t addr;
		cpu_pkg::word_t data;

		fill_memories();
		read_word(count);
		for (int i = 0; i < count; i++) begin
			read_word(data);
			prog[i] = data;
		end
		read_word(count);
		for (int i = 0; i < count; i++) begin
			read_word(addr);
			read_word(data);
			dmem[addr[11:0]] = data;
		end
		exp_addr.delete();
		exp_data.delete();
		read_word(count);
		for (int i = 0; i < count; i++) begin
			read_word(addr);
			read_word(data);
			exp_addr.push_back(addr[11:0]);
			exp_data.push_back(data);
		end
		read_word(exp_ovf);
		read_word(budget);
	endtask

	task automatic check_quiet(input string where);
		assert (dm_write === 1'b0 && dm_read === 1'b0 && alu_overflow === 1'b0)
			else mismatch($sformatf("memory strobes or alu_overflow not low %s", where));
	endtask

	task automatic hold_reset();
		for (int i = 1; i < RESET_CYCLES; i++) begin
			@(posedge clk);
			@(negedge clk);
			check_quiet("during reset");
		end
		@(posedge clk);
		#1 reset = 1'b0;
	endtask

	// store and overflow tracking for one cycle sampled mid cycle
	task automatic watch_cycle(input int index, inout int stores, inout int pulses,
		inout logic ovf_prev);
		assert (im_read && im_enable && dm_enable)
			else mismatch("memory enables low while out of reset");
		if (dm_write) begin
			assert (stores < exp_addr.size())
				else mismatch($sformatf("test %0d: extra store to %0h", index, dm_address));
			assert (dm_address == exp_addr[stores] && dm_in == exp_data[stores])
				else mismatch($sformatf("test %0d store %0d: %0h <= %08h, expected %0h <= %08h",
					index, stores, dm_address, dm_in, exp_addr[stores], exp_data[stores]));
			stores++;
		end
		if (alu_overflow) begin
			assert (!ovf_prev)
				else mismatch($sformatf("test %0d: alu_overflow longer than a cycle", index));
			pulses++;
		end
		ovf_prev = alu_overflow;
	endtask

	task automatic run_test(input int index);
		cpu_pkg::word_t exp_ovf;
		cpu_pkg::word_t budget;
		int stores;
		int pulses;
		int cycles;
		logic ovf_prev;

		@(posedge clk);
		#1 reset = 1'b1;
		@(negedge clk);
		load_test(exp_ovf, budget);
		hold_reset();
		stores = 0;
		pulses = 0;
		cycles = 0;
		ovf_prev = 1'b0;
		while (stores < exp_addr.size()) begin
			@(negedge clk);
			cycles++;
			if (cycles > budget)
				give_up($sformatf("timeout in test %0d: %0d of %0d stores after %0d cycles",
					index, stores, exp_addr.size(), cycles - 1));
			// nothing can reach MEM this early
			if (cycles <= 3)
				check_quiet("right after reset");
			watch_cycle(index, stores, pulses, ovf_prev);
		end
		repeat (DRAIN_CYCLES) begin
			@(negedge clk);
			watch_cycle(index, stores, pulses, ovf_prev);
		end
		assert (pulses == exp_ovf)
			else mismatch($sformatf("test %0d: %0d alu_overflow pulses, expected %0d",
				index, pulses, exp_ovf));
		$display("test %0d done: %0d stores, %0d overflow pulses", index, stores, pulses);
	endtask

	initial begin
		cpu_pkg::word_t num_tests;

		reset = 1'b1;
		instruction = NOP;
		cursor = 0;
		fill_memories();
		$readmemh("test/cpu_tests.txt", test_words);
		read_word(num_tests);
		for (int t = 0; t < num_tests; t++)
			run_test(t);
		$display("Testbench passed");
		$finish;
	end

endmodule
